/* src/raster_params.svh */
// Fixed-point widths, triangle shape counts and subsample pitch shift
`ifndef RASTER_PARAMS_SVH
`define RASTER_PARAMS_SVH

// Width of every coordinate and colour word
`define RASTER_SIGFIG 24

// Fraction bits in a coordinate
// Integer part is the upper RASTER_SIGFIG - RASTER_RADIX bits
`define RASTER_RADIX 10

// Vertices per triangle
`define RASTER_VERTS 3

// Axes per vertex, ordered x, y, z
`define RASTER_AXIS 3

// Colour channels per triangle
`define RASTER_COLORS 3

// One-hot subsample code shifted by this gives the grid pitch
// Code 1000 lands on bit RADIX, one full pixel
// Code 0001 lands on bit RADIX-3, an eighth of a pixel
`define RASTER_SUBSAMPLE_SHIFT (`RASTER_RADIX - 3)

`endif

/* src/raster_pkg.sv */
// Coordinate, colour, subsample code and iterator state types
`include "raster_params.svh"

package raster_pkg;

    // Signed fixed point position
    // Upper bits are the integer part, low RASTER_RADIX bits the fraction
    typedef logic signed [`RASTER_SIGFIG-1:0] coord_t;

    // Unsigned colour channel value
    typedef logic [`RASTER_SIGFIG-1:0] color_t;

    // One-hot grid pitch code
    // 1000 pixel, 0100 half, 0010 quarter, 0001 eighth
    typedef logic [3:0] subsample_t;

    // Iterator control states
    // Wait tracks the upstream inputs, test walks the box
    typedef enum logic {
        WAIT_STATE = 1'b0,
        TEST_STATE = 1'b1
    } iter_state_t;

endpackage

/* src/iter_fsm.sv */
// Wait/test control FSM driving load, step, halt and sample-valid
`timescale 1ns/100ps

module iter_fsm (
    input  logic clk,
    input  logic rst,
    input  logic tri_valid,
    input  logic at_right_edge,
    input  logic at_top_edge,
    output logic load,
    output logic step,
    output logic halt_n,
    output logic sample_valid
);
    import raster_pkg::*;

    iter_state_t state;
    iter_state_t next_state;
    logic        at_end_box;

    // Last sample of the box is the top-right corner
    assign at_end_box = at_right_edge && at_top_edge;

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            WAIT_STATE: begin
                // Take the triangle on the first valid seen
                if (tri_valid) begin
                    next_state = TEST_STATE;
                end
            end
            TEST_STATE: begin
                // Walk until the top-right sample has been shown
                if (at_end_box) begin
                    next_state = WAIT_STATE;
                end
            end
        endcase
    end

    // State and handshake flops
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= WAIT_STATE;
            sample_valid <= 1'b0;
            // Upstream free to advance out of reset
            halt_n       <= 1'b1;
        end else begin
            state        <= next_state;
            // Every cycle spent in test carries a sample
            sample_valid <= (next_state == TEST_STATE);
            // Hold upstream for the whole walk
            halt_n       <= (next_state == WAIT_STATE);
        end
    end

    // Stepper and hold registers follow the inputs while waiting
    assign load = (state == WAIT_STATE);

    // Advance one grid point per cycle of the walk
    assign step = (state == TEST_STATE);

    // Valid triangle in wait starts a walk with upstream held
    assert property (@(posedge clk) disable iff (rst)
        (state == WAIT_STATE && tri_valid)
        |=> (state == TEST_STATE && sample_valid && !halt_n));

    // No triangle keeps the iterator idle
    assert property (@(posedge clk) disable iff (rst)
        (state == WAIT_STATE && !tri_valid)
        |=> (state == WAIT_STATE && !sample_valid && halt_n));

    // Top-right corner ends the walk and releases upstream
    assert property (@(posedge clk) disable iff (rst)
        (state == TEST_STATE && at_end_box)
        |=> (state == WAIT_STATE && !sample_valid && halt_n));

    // Otherwise the walk carries on
    assert property (@(posedge clk) disable iff (rst)
        (state == TEST_STATE && !at_end_box)
        |=> (state == TEST_STATE && sample_valid && !halt_n));

endmodule

/* src/sample_stepper.sv */
// Two-dimensional sample counter with stored box, edge flags and in-box checks
`timescale 1ns/100ps
`include "raster_params.svh"

module sample_stepper (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,
    input  logic                   step,
    input  raster_pkg::subsample_t subsample,
    input  raster_pkg::coord_t     box_min_x,
    input  raster_pkg::coord_t     box_min_y,
    input  raster_pkg::coord_t     box_max_x,
    input  raster_pkg::coord_t     box_max_y,
    output raster_pkg::coord_t     sample_x,
    output raster_pkg::coord_t     sample_y,
    output logic                   at_right_edge,
    output logic                   at_top_edge
);
    import raster_pkg::*;

    // Box captured at load and held for the walk
    coord_t min_x_q;
    coord_t min_y_q;
    coord_t max_x_q;
    coord_t max_y_q;

    // Grid spacing in coordinate units
    coord_t pitch;

    // Zero-extend the one-hot code, then move it onto the fraction bits
    assign pitch = coord_t'({{(`RASTER_SIGFIG - $bits(subsample_t)){1'b0}}, subsample})
                   << `RASTER_SUBSAMPLE_SHIFT;

    // Signed compares so boxes left of or below the origin work
    assign at_right_edge = (sample_x >= max_x_q);
    assign at_top_edge   = (sample_y >= max_y_q);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            min_x_q  <= '0;
            min_y_q  <= '0;
            max_x_q  <= '0;
            max_y_q  <= '0;
            sample_x <= '0;
            sample_y <= '0;
        end else if (load) begin
            min_x_q  <= box_min_x;
            min_y_q  <= box_min_y;
            max_x_q  <= box_max_x;
            max_y_q  <= box_max_y;
            // First sample is the lower-left corner
            sample_x <= box_min_x;
            sample_y <= box_min_y;
        end else if (step) begin
            if (at_right_edge) begin
                // Wrap to the start of the next row up
                sample_x <= min_x_q;
                // Top row has no next row so y stays put
                if (!at_top_edge) begin
                    sample_y <= sample_y + pitch;
                end
            end else begin
                sample_x <= sample_x + pitch;
            end
        end
    end

    // Every sample of the walk lies inside the stored box
    // Left and bottom bounds
    assert property (@(posedge clk) disable iff (rst)
        step |-> (min_x_q <= sample_x));

    assert property (@(posedge clk) disable iff (rst)
        step |-> (min_y_q <= sample_y));

    // Right and top bounds, tripped by a box off the pitch grid
    assert property (@(posedge clk) disable iff (rst)
        step |-> (sample_x <= max_x_q));

    assert property (@(posedge clk) disable iff (rst)
        step |-> (sample_y <= max_y_q));

endmodule

/* src/prim_hold.sv */
// Triangle vertex and colour holding registers captured at triangle accept
`timescale 1ns/100ps
`include "raster_params.svh"

module prim_hold (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  raster_pkg::coord_t tri_vert [`RASTER_VERTS-1:0][`RASTER_AXIS-1:0],
    input  raster_pkg::color_t tri_color [`RASTER_COLORS-1:0],
    output raster_pkg::coord_t out_vert [`RASTER_VERTS-1:0][`RASTER_AXIS-1:0],
    output raster_pkg::color_t out_color [`RASTER_COLORS-1:0]
);

    // Vertex words
    // Loaded with the box so each sample carries its own triangle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int v = 0; v < `RASTER_VERTS; v++) begin
                for (int a = 0; a < `RASTER_AXIS; a++) begin
                    out_vert[v][a] <= '0;
                end
            end
        end else if (load) begin
            out_vert <= tri_vert;
        end
    end

    // Colour channels
    // Held through the walk while upstream moves on
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int c = 0; c < `RASTER_COLORS; c++) begin
                out_color[c] <= '0;
            end
        end else if (load) begin
            out_color <= tri_color;
        end
    end

endmodule

/* src/bbox_sample_iter.sv */
// Bounding-box sample iterator top level joining control FSM, stepper and hold registers
`timescale 1ns/100ps
`include "raster_params.svh"

module bbox_sample_iter (
    input  logic                   clk,
    input  logic                   rst,
    // Upstream triangle and box
    input  logic                   tri_valid,
    input  raster_pkg::coord_t     box_min_x,
    input  raster_pkg::coord_t     box_min_y,
    input  raster_pkg::coord_t     box_max_x,
    input  raster_pkg::coord_t     box_max_y,
    input  raster_pkg::coord_t     tri_vert [`RASTER_VERTS-1:0][`RASTER_AXIS-1:0],
    input  raster_pkg::color_t     tri_color [`RASTER_COLORS-1:0],
    // Steady for the length of a walk
    input  raster_pkg::subsample_t subsample,
    // Downstream sample stream
    output logic                   sample_valid,
    output raster_pkg::coord_t     sample_x,
    output raster_pkg::coord_t     sample_y,
    output raster_pkg::coord_t     out_vert [`RASTER_VERTS-1:0][`RASTER_AXIS-1:0],
    output raster_pkg::color_t     out_color [`RASTER_COLORS-1:0],
    // Low holds the upstream box stage
    output logic                   halt_n
);

    logic load;
    logic step;
    logic at_right_edge;
    logic at_top_edge;

    // Control
    iter_fsm u_fsm (
        .clk           (clk),
        .rst           (rst),
        .tri_valid     (tri_valid),
        .at_right_edge (at_right_edge),
        .at_top_edge   (at_top_edge),
        .load          (load),
        .step          (step),
        .halt_n        (halt_n),
        .sample_valid  (sample_valid)
    );

    // Sample position walk
    sample_stepper u_stepper (
        .clk           (clk),
        .rst           (rst),
        .load          (load),
        .step          (step),
        .subsample     (subsample),
        .box_min_x     (box_min_x),
        .box_min_y     (box_min_y),
        .box_max_x     (box_max_x),
        .box_max_y     (box_max_y),
        .sample_x      (sample_x),
        .sample_y      (sample_y),
        .at_right_edge (at_right_edge),
        .at_top_edge   (at_top_edge)
    );

    // Triangle payload travelling with every sample
    prim_hold u_hold (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .tri_vert  (tri_vert),
        .tri_color (tri_color),
        .out_vert  (out_vert),
        .out_color (out_color)
    );

endmodule

/* tb/tb_clock.sv */
// Testbench clock and power-on reset generator
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst
);

    // 20 ns period, first rising edge at 10 ns
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Reset held across three rising edges
    // Released 2 ns after the third, in step with the input drive
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

/* tb/tb_bbox_sample_iter.sv */
// Sample iterator testbench with stimulus file reader, upstream driver and sample stream checker
`timescale 1ns/100ps
`include "raster_params.svh"

module tb_bbox_sample_iter;
    import raster_pkg::*;

    localparam int MAX_TRIS = 32;

    logic       clk;
    logic       rst;

    // DUT inputs
    logic       tri_valid;
    coord_t     box_min_x;
    coord_t     box_min_y;
    coord_t     box_max_x;
    coord_t     box_max_y;
    coord_t     tri_vert [`RASTER_VERTS-1:0][`RASTER_AXIS-1:0];
    color_t     tri_color [`RASTER_COLORS-1:0];
    subsample_t subsample;

    // DUT outputs
    logic       sample_valid;
    coord_t     sample_x;
    coord_t     sample_y;
    coord_t     out_vert [`RASTER_VERTS-1:0][`RASTER_AXIS-1:0];
    color_t     out_color [`RASTER_COLORS-1:0];
    logic       halt_n;

    // Triangle table filled from the stimulus file
    int         num_tris;
    int         gap_tab [MAX_TRIS];
    subsample_t code_tab [MAX_TRIS];
    coord_t     min_x_tab [MAX_TRIS];
    coord_t     min_y_tab [MAX_TRIS];
    coord_t     max_x_tab [MAX_TRIS];
    coord_t     max_y_tab [MAX_TRIS];
    coord_t     vert_tab [MAX_TRIS][`RASTER_VERTS-1:0][`RASTER_AXIS-1:0];
    color_t     color_tab [MAX_TRIS][`RASTER_COLORS-1:0];

    integer     seed;
    // Oldest triangle not yet taken by the DUT
    int         next_tri;
    int         cycle_count = 0;
    int         cycle_limit = 0;

    // Checker walk state
    int         walk_tri;
    int         walk_left;
    int         walk_col;
    int         walk_row;
    int         walk_cols;
    int         walk_pitch;
    int         accept_count;
    int         tris_done;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    bbox_sample_iter UUT (
        .clk          (clk),
        .rst          (rst),
        .tri_valid    (tri_valid),
        .box_min_x    (box_min_x),
        .box_min_y    (box_min_y),
        .box_max_x    (box_max_x),
        .box_max_y    (box_max_y),
        .tri_vert     (tri_vert),
        .tri_color    (tri_color),
        .subsample    (subsample),
        .sample_valid (sample_valid),
        .sample_x     (sample_x),
        .sample_y     (sample_y),
        .out_vert     (out_vert),
        .out_color    (out_color),
        .halt_n       (halt_n)
    );

    // Grid pitch in coordinate units, one pixel is 1 << RADIX
    function automatic int pitch_of(input subsample_t code);
        case (code)
            4'b1000: pitch_of = 1 << `RASTER_RADIX;
            4'b0100: pitch_of = 1 << (`RASTER_RADIX - 1);
            4'b0010: pitch_of = 1 << (`RASTER_RADIX - 2);
            4'b0001: pitch_of = 1 << (`RASTER_RADIX - 3);
            default: pitch_of = 0;
        endcase
    endfunction

    // Grid points from lo to hi inclusive
    function automatic int span_count(input coord_t lo, input coord_t hi, input int pitch);
        span_count = (int'(hi) - int'(lo)) / pitch + 1;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_equal(input string name,
                               input logic [`RASTER_SIGFIG-1:0] expected,
                               input logic [`RASTER_SIGFIG-1:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic load_stimulus();
        int                        fd;
        int                        count;
        int                        gap;
        string                     line;
        subsample_t                code;
        logic [`RASTER_SIGFIG-1:0] bx0, bx1, bx2, bx3;
        logic [`RASTER_SIGFIG-1:0] w0, w1, w2, w3, w4, w5, w6, w7, w8, w9, w10, w11;
        logic [`RASTER_SIGFIG-1:0] words [12];
        fd = $fopen("tb/iter_stim.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the stimulus file tb/iter_stim.txt");
        end
        num_tris = 0;
        // Fixed slack for reset and the final idle cycles
        cycle_limit = 20;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Skip blank and comment lines
            if (line.len() > 1 && line.getc(0) != "#") begin
                count = $sscanf(line, "%d %b %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                gap, code, bx0, bx1, bx2, bx3,
                                w0, w1, w2, w3, w4, w5, w6, w7, w8, w9, w10, w11);
                if (count != 18) begin
                    fail_run($sformatf("Stimulus line %0d has %0d fields", num_tris, count));
                end
                if (num_tris == MAX_TRIS || pitch_of(code) == 0) begin
                    fail_run("Stimulus holds too many triangles or a code that is not one-hot");
                end
                gap_tab[num_tris]   = gap;
                code_tab[num_tris]  = code;
                min_x_tab[num_tris] = bx0;
                min_y_tab[num_tris] = bx1;
                max_x_tab[num_tris] = bx2;
                max_y_tab[num_tris] = bx3;
                words = '{w0, w1, w2, w3, w4, w5, w6, w7, w8, w9, w10, w11};
                // Zero words become random values
                for (int i = 0; i < 12; i++) begin
                    if (words[i] == '0) begin
                        words[i] = $random(seed);
                    end
                end
                for (int i = 0; i < 9; i++) begin
                    vert_tab[num_tris][i / 3][i % 3] = words[i];
                end
                for (int c = 0; c < `RASTER_COLORS; c++) begin
                    color_tab[num_tris][c] = words[9 + c];
                end
                // Idle slots, samples and handshake slack
                cycle_limit += gap + 4
                               + span_count(bx0, bx2, pitch_of(code))
                               * span_count(bx1, bx3, pitch_of(code));
                num_tris++;
            end
        end
        $fclose(fd);
        if (num_tris == 0) begin
            fail_run("Stimulus file holds no triangles");
        end
    endtask

    task automatic drive_triangle(input int t);
        tri_valid = 1'b1;
        box_min_x = min_x_tab[t];
        box_min_y = min_y_tab[t];
        box_max_x = max_x_tab[t];
        box_max_y = max_y_tab[t];
        tri_vert  = vert_tab[t];
        tri_color = color_tab[t];
    endtask

    // Idle slot with junk on every data line
    task automatic drive_idle();
        tri_valid = 1'b0;
        box_min_x = $random(seed);
        box_min_y = $random(seed);
        box_max_x = $random(seed);
        box_max_y = $random(seed);
        for (int v = 0; v < `RASTER_VERTS; v++) begin
            for (int a = 0; a < `RASTER_AXIS; a++) begin
                tri_vert[v][a] = $random(seed);
            end
        end
        for (int c = 0; c < `RASTER_COLORS; c++) begin
            tri_color[c] = $random(seed);
        end
    endtask

    // Step to 2 ns past the next rising edge
    // Pitch only changes once no walk is running
    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (halt_n && next_tri < num_tris) begin
            subsample = code_tab[next_tri];
        end
    endtask

    // Hold the current slot until an edge sees halt_n high
    task automatic wait_slot_taken();
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = halt_n;
            next_cycle();
        end
    endtask

    initial begin : stimulus
        seed         = 32'ha3dfc9ff;
        next_tri     = 0;
        walk_left    = 0;
        accept_count = 0;
        tris_done    = 0;
        tri_valid    = 1'b0;
        box_min_x    = '0;
        box_min_y    = '0;
        box_max_x    = '0;
        box_max_y    = '0;
        subsample    = 4'b1000;
        for (int v = 0; v < `RASTER_VERTS; v++) begin
            for (int a = 0; a < `RASTER_AXIS; a++) begin
                tri_vert[v][a] = '0;
            end
        end
        for (int c = 0; c < `RASTER_COLORS; c++) begin
            tri_color[c] = '0;
        end
        load_stimulus();
        subsample = code_tab[0];
        wait (rst == 1'b0);
        for (int t = 0; t < num_tris; t++) begin
            for (int g = 0; g < gap_tab[t]; g++) begin
                drive_idle();
                wait_slot_taken();
            end
            // Held through the previous walk, taken once halt_n rises
            drive_triangle(t);
            wait_slot_taken();
            next_tri = t + 1;
        end
        drive_idle();
        while (tris_done < num_tris) begin
            next_cycle();
        end
        // A few idle cycles checked after the last walk
        repeat (3) next_cycle();
        $display("Result: PASSED");
        $finish;
    end

    // Sample stream checker
    // Outputs and inputs are both steady at the falling edge
    always @(negedge clk) begin : monitor
        string prefix;
        int    exp_x;
        int    exp_y;
        if (rst === 1'b0) begin
            if (walk_left == 0) begin
                check_equal("idle sample_valid", 1'b0, sample_valid);
                check_equal("idle halt_n", 1'b1, halt_n);
                // Valid with halt_n high means the next edge takes it
                if (tri_valid) begin
                    if (accept_count >= num_tris) begin
                        fail_run("A triangle was taken beyond the end of the stimulus");
                    end
                    walk_tri   = accept_count;
                    walk_pitch = pitch_of(code_tab[walk_tri]);
                    walk_cols  = span_count(min_x_tab[walk_tri], max_x_tab[walk_tri], walk_pitch);
                    walk_left  = walk_cols
                                 * span_count(min_y_tab[walk_tri], max_y_tab[walk_tri], walk_pitch);
                    walk_col   = 0;
                    walk_row   = 0;
                    accept_count++;
                end
            end else begin
                prefix = $sformatf("tri %0d sample %0d", walk_tri, walk_row * walk_cols + walk_col);
                // Raster order from the lower-left corner
                exp_x  = int'(min_x_tab[walk_tri]) + walk_col * walk_pitch;
                exp_y  = int'(min_y_tab[walk_tri]) + walk_row * walk_pitch;
                check_equal({prefix, " sample_valid"}, 1'b1, sample_valid);
                check_equal({prefix, " halt_n"}, 1'b0, halt_n);
                check_equal({prefix, " sample_x"}, coord_t'(exp_x), sample_x);
                check_equal({prefix, " sample_y"}, coord_t'(exp_y), sample_y);
                for (int v = 0; v < `RASTER_VERTS; v++) begin
                    for (int a = 0; a < `RASTER_AXIS; a++) begin
                        check_equal($sformatf("%s vert %0d axis %0d", prefix, v, a),
                                    vert_tab[walk_tri][v][a], out_vert[v][a]);
                    end
                end
                for (int c = 0; c < `RASTER_COLORS; c++) begin
                    check_equal($sformatf("%s color %0d", prefix, c),
                                color_tab[walk_tri][c], out_color[c]);
                end
                walk_left--;
                if (walk_left == 0) begin
                    tris_done++;
                end else begin
                    walk_col++;
                    if (walk_col == walk_cols) begin
                        walk_col = 0;
                        walk_row++;
                    end
                end
            end
        end
    end

    // Run length guard
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            fail_run($sformatf("Timeout: sample stream did not finish within %0d cycles",
                               cycle_limit));
        end
    end

endmodule

/* tb/iter_stim.txt */
# gap code min_x min_y max_x max_y v0x v0y v0z v1x v1y v1z v2x v2y v2z c0 c1 c2
# Gap counts idle slots before the triangle
# Code is one-hot binary and every other word is hex
# A zero vertex or colour word is replaced by a random value
# Pixel pitch 4x3 after idle cycles out of reset
3 1000 000000 000000 000C00 000800 400 0 0 C00 400 0 0 800 0 FF 0 0
# Single point straight after
0 1000 001400 000C00 001400 000C00 0 0 0 0 0 0 0 0 0 0 0 0
# Half pixel back to back
0 0100 000800 000400 000E00 000800 0 0 0 0 0 0 0 0 0 0 0 0
# Quarter pixel below and left of the origin
2 0010 FFFC00 FFFE00 000000 000000 0 0 0 0 0 0 0 0 0 0 0 0
# Eighth pixel
0 0001 000100 000200 000300 000300 0 0 0 0 0 0 0 0 0 0 0 0
# Single row in negative space
1 1000 FFF000 FFF800 FFF400 FFF800 0 0 0 0 0 0 0 0 0 0 0 0
# Single column
0 0100 002000 001000 002000 001400 0 0 0 0 0 0 0 0 0 0 0 0
4 0010 000000 000000 000300 000000 0 0 0 0 0 0 0 0 0 0 0 0
0 0001 003F80 003F80 003F80 003F80 0 0 0 0 0 0 0 0 0 0 0 0
0 1000 010000 010000 011000 010800 0 0 0 0 0 0 0 0 0 0 0 0
2 0001 FFFF00 FFFF00 000000 000080 0 0 0 0 0 0 0 0 0 0 0 0
0 0100 000000 000000 000400 000400 100 200 0 300 100 0 200 300 0 FF 80 40

/* tb.f */
+incdir+src
src/raster_pkg.sv
src/iter_fsm.sv
src/sample_stepper.sv
src/prim_hold.sv
src/bbox_sample_iter.sv
tb/tb_clock.sv
tb/tb_bbox_sample_iter.sv

/* Bender.yml */
package:
  name: bbox_sample_iter

export_include_dirs:
  - src

sources:
  # RTL
  - include_dirs:
      - src
    files:
      - src/raster_pkg.sv
      - src/iter_fsm.sv
      - src/sample_stepper.sv
      - src/prim_hold.sv
      - src/bbox_sample_iter.sv
  # Testbench
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_clock.sv
      - tb/tb_bbox_sample_iter.sv
